// File: axis_input_pipe.f
input_pipe_pkg.sv
axis_image_pipe.sv
axis_image_shift_buffer.sv
axis_weight_rotator.sv
axis_input_pipe.sv
axis_input_pipe_asserts.sv
axis_input_pipe_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= axis_input_pipe_tb
FILELIST   ?= axis_input_pipe.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

SRCS := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: axis_input_pipe_tb.sv
`default_nettype none

module axis_input_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    input_pipe_pkg::kh_t     kh;
    logic                    is_max;
    logic                    is_lrelu;
    input_pipe_pkg::kw_t     kw;
    input_pipe_pkg::blocks_t blocks_1;
    logic                    is_1x1;
    logic                    cols_1_k2;
    int                      n_w;
    int                      n_pix;      // n_pix * (kh + 1) == (blocks_1 + 1) * n_w.
    logic                    stall;
  } row_t;

  logic aclk;
  logic reset;
  logic s_axis_pixels_1_tvalid;
  logic s_axis_pixels_1_tlast;
  input_pipe_pkg::pix_edges_t s_axis_pixels_1_tdata;
  logic s_axis_pixels_1_tready;
  logic s_axis_pixels_2_tvalid;
  logic s_axis_pixels_2_tlast;
  input_pipe_pkg::pix_edges_t s_axis_pixels_2_tdata;
  logic s_axis_pixels_2_tready;
  logic s_axis_weights_tvalid;
  logic s_axis_weights_tlast;
  input_pipe_pkg::weights_t s_axis_weights_tdata;
  logic s_axis_weights_tready;
  logic m_axis_tready;
  logic m_axis_tvalid;
  logic m_axis_tlast;
  input_pipe_pkg::conv_user_t m_axis_tuser;
  input_pipe_pkg::pix_units_t m_axis_pixels_1_tdata;
  input_pipe_pkg::pix_units_t m_axis_pixels_2_tdata;
  input_pipe_pkg::weights_t   m_axis_weights_tdata;

  row_t rows [5];
  input_pipe_pkg::pix_edges_t pix_1 [5][16];
  input_pipe_pkg::pix_edges_t pix_2 [5][16];
  input_pipe_pkg::weights_t   w_data [5][16];
  logic [31:0] lfsr_state;

  axis_input_pipe uut (.*);

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  // Fibonacci LFSR, taps 32 22 2 1.
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_pixels(input string name, input input_pipe_pkg::pix_units_t exp,
                              input input_pipe_pkg::pix_units_t act);
    if (act !== exp)
      abort_run($sformatf("FAIL %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_weights(input string name, input input_pipe_pkg::weights_t exp,
                               input input_pipe_pkg::weights_t act);
    if (act !== exp)
      abort_run($sformatf("FAIL %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_user(input string name, input input_pipe_pkg::conv_user_t exp,
                            input input_pipe_pkg::conv_user_t act);
    if (act !== exp)
      abort_run($sformatf("FAIL %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("FAIL %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  // Block flags read low while no beat is offered.
  task automatic check_gated_flags();
    check_last("m_axis_tuser.is_top_block", 1'b0, m_axis_tuser.is_top_block);
    check_last("m_axis_tuser.is_bottom_block", 1'b0, m_axis_tuser.is_bottom_block);
    check_last("m_axis_tuser.is_cols_1_k2", 1'b0, m_axis_tuser.is_cols_1_k2);
    check_last("m_axis_tuser.is_cin_last", 1'b0, m_axis_tuser.is_cin_last);
  endtask

  task automatic make_data();
    for (int r = 0; r < 5; r++) begin
      for (int b = 0; b < 16; b++) begin
        for (int i = 0; i < input_pipe_pkg::UNITS_EDGES; i++) begin
          pix_1[r][b][i] = input_pipe_pkg::word_t'(lfsr_take(8));
          pix_2[r][b][i] = input_pipe_pkg::word_t'(lfsr_take(8));
        end
        for (int i = 0; i < input_pipe_pkg::W_WORDS; i++)
          w_data[r][b][i] = input_pipe_pkg::word_t'(lfsr_take(8));
      end
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer.
  task automatic wait_accept(input int port, input string name);
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    while (!taken && cycles < 2000) begin
      #25;  // Inputs have settled here.
      case (port)
        0:       taken = s_axis_weights_tready;
        1:       taken = s_axis_pixels_1_tready;
        default: taken = s_axis_pixels_2_tready;
      endcase
      @(negedge aclk);
      cycles++;
    end
    if (!taken)
      abort_run($sformatf("Timeout: %s never took its beat.", name));
  endtask

  task automatic push_pixel(input int stream, input input_pipe_pkg::pix_edges_t beat,
                            input logic last);
    if (stream == 1) begin
      s_axis_pixels_1_tvalid = 1'b1;
      s_axis_pixels_1_tdata  = beat;
      s_axis_pixels_1_tlast  = last;
      wait_accept(1, "pixel stream 1");
    end else begin
      s_axis_pixels_2_tvalid = 1'b1;
      s_axis_pixels_2_tdata  = beat;
      s_axis_pixels_2_tlast  = last;
      wait_accept(2, "pixel stream 2");
    end
  endtask

  task automatic send_pixels(input int stream);
    input_pipe_pkg::im_cfg_t    cfg;
    input_pipe_pkg::pix_edges_t beat;
    for (int r = 0; r < 5; r++) begin
      cfg.reserved   = '0;
      cfg.is_lrelu   = rows[r].is_lrelu;
      cfg.is_max     = rows[r].is_max;
      cfg.kernel_h_1 = rows[r].kh;
      beat    = '0;
      beat[0] = input_pipe_pkg::word_t'(cfg);
      push_pixel(stream, beat, 1'b0);
      for (int b = 0; b < rows[r].n_pix; b++)
        push_pixel(stream, (stream == 1) ? pix_1[r][b] : pix_2[r][b], b == rows[r].n_pix - 1);
    end
    if (stream == 1)
      s_axis_pixels_1_tvalid = 1'b0;
    else
      s_axis_pixels_2_tvalid = 1'b0;
  endtask

  task automatic send_weights();
    input_pipe_pkg::w_cfg_t cfg;
    for (int r = 0; r < 5; r++) begin
      cfg.reserved     = 1'b0;
      cfg.is_cols_1_k2 = rows[r].cols_1_k2;
      cfg.is_1x1       = rows[r].is_1x1;
      cfg.blocks_1     = rows[r].blocks_1;
      cfg.kernel_w_1   = rows[r].kw;
      s_axis_weights_tvalid = 1'b1;
      s_axis_weights_tdata  = '0;
      s_axis_weights_tdata[0] = input_pipe_pkg::word_t'(cfg);
      s_axis_weights_tlast  = 1'b0;
      wait_accept(0, "weight stream");
      for (int b = 0; b < rows[r].n_w; b++) begin
        s_axis_weights_tdata = w_data[r][b];
        s_axis_weights_tlast = (b == rows[r].n_w - 1);
        wait_accept(0, "weight stream");
      end
    end
    s_axis_weights_tvalid = 1'b0;
  endtask

  // Returns with a beat on the output that transfers at the next rising edge.
  task automatic wait_output(input logic stall);
    int          cycles;
    logic        got;
    logic [31:0] bits;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < 2000) begin
      @(negedge aclk);
      bits          = lfsr_take(1);
      m_axis_tready = !stall || bits[0];
      #25;
      got = m_axis_tvalid && m_axis_tready;
      if (!m_axis_tvalid)
        check_gated_flags();
      cycles++;
    end
    if (!got)
      abort_run("Timeout: no output beat arrived.");
  endtask

  task automatic check_outputs();
    int pass_no;
    int idx;
    int j;
    input_pipe_pkg::pix_units_t exp_1;
    input_pipe_pkg::pix_units_t exp_2;
    input_pipe_pkg::conv_user_t exp_user;
    for (int r = 0; r < 5; r++) begin
      j = 0;
      for (int p = 0; p < rows[r].n_pix; p++) begin
        for (int k = 0; k <= int'(rows[r].kh); k++) begin
          wait_output(rows[r].stall);
          for (int i = 0; i < input_pipe_pkg::UNITS; i++) begin
            exp_1[i] = pix_1[r][p][k + i];  // Window k of the padded row.
            exp_2[i] = pix_2[r][p][k + i];
          end
          pass_no = j / rows[r].n_w;
          idx     = j % rows[r].n_w;
          exp_user.is_not_max      = !rows[r].is_max;
          exp_user.is_max          = rows[r].is_max;
          exp_user.is_1x1          = rows[r].is_1x1;
          exp_user.is_lrelu        = rows[r].is_lrelu;
          exp_user.is_top_block    = (pass_no == 0);
          exp_user.is_bottom_block = (pass_no == int'(rows[r].blocks_1));
          exp_user.is_cols_1_k2    = rows[r].cols_1_k2;
          exp_user.is_cin_last     = (idx == rows[r].n_w - 1);
          exp_user.kernel_w_1      = rows[r].kw;
          exp_user.kernel_h_1      = rows[r].kh;
          check_pixels("m_axis_pixels_1_tdata", exp_1, m_axis_pixels_1_tdata);
          check_pixels("m_axis_pixels_2_tdata", exp_2, m_axis_pixels_2_tdata);
          check_weights("m_axis_weights_tdata", w_data[r][idx], m_axis_weights_tdata);
          check_user("m_axis_tuser", exp_user, m_axis_tuser);
          check_last("m_axis_tlast", exp_user.is_cin_last && exp_user.is_bottom_block,
                     m_axis_tlast);
          j++;
        end
      end
    end
    repeat (20) begin
      @(negedge aclk);
      m_axis_tready = 1'b1;
      #25;
      check_last("m_axis_tvalid", 1'b0, m_axis_tvalid);  // No extra beats.
    end
  endtask

  initial begin
    reset                  = 1'b1;
    s_axis_pixels_1_tvalid = 1'b0;
    s_axis_pixels_1_tlast  = 1'b0;
    s_axis_pixels_1_tdata  = '0;
    s_axis_pixels_2_tvalid = 1'b0;
    s_axis_pixels_2_tlast  = 1'b0;
    s_axis_pixels_2_tdata  = '0;
    s_axis_weights_tvalid  = 1'b0;
    s_axis_weights_tlast   = 1'b0;
    s_axis_weights_tdata   = '0;
    m_axis_tready          = 1'b0;
    lfsr_state             = 32'hb4ac_6fb9;

    // kh, max, lrelu, kw, blocks_1, 1x1, cols_1_k2, weight beats, pixel beats, stall
    rows[0] = '{2'd2, 1'b0, 1'b1, 2'd2, 3'd1, 1'b0, 1'b0, 3, 2, 1'b0};
    rows[1] = '{2'd0, 1'b1, 1'b0, 2'd0, 3'd0, 1'b1, 1'b1, 4, 4, 1'b1};
    rows[2] = '{2'd1, 1'b1, 1'b1, 2'd1, 3'd2, 1'b0, 1'b1, 4, 6, 1'b1};
    rows[3] = '{2'd2, 1'b0, 1'b0, 2'd2, 3'd7, 1'b0, 1'b0, 3, 8, 1'b1};
    rows[4] = '{2'd2, 1'b0, 1'b1, 2'd2, 3'd0, 1'b0, 1'b0, 15, 5, 1'b0};
    make_data();

    repeat (10) @(negedge aclk);
    reset = 1'b0;
    #25;
    check_last("m_axis_tvalid", 1'b0, m_axis_tvalid);
    check_last("s_axis_weights_tready", 1'b1, s_axis_weights_tready);
    @(negedge aclk);

    fork
      send_pixels(1);
      send_pixels(2);
      send_weights();
      check_outputs();
    join

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: axis_input_pipe_asserts.sv
`default_nettype none

module axis_input_pipe_asserts (
  input logic                       aclk,
  input logic                       reset,
  input logic                       s_axis_weights_tvalid,
  input logic                       s_axis_weights_tready,
  input logic                       s_axis_weights_tlast,
  input input_pipe_pkg::weights_t   s_axis_weights_tdata,
  input logic                       m_axis_tvalid,
  input logic                       m_axis_tready,
  input logic                       m_axis_tlast,
  input input_pipe_pkg::conv_user_t m_axis_tuser,
  input input_pipe_pkg::pix_units_t m_axis_pixels_1_tdata,
  input input_pipe_pkg::pix_units_t m_axis_pixels_2_tdata,
  input input_pipe_pkg::weights_t   m_axis_weights_tdata
);
  timeunit 1ns;
  timeprecision 1ps;

  out_held: assert property (@(posedge aclk) disable iff (reset)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tlast)
      && $stable(m_axis_tuser) && $stable(m_axis_pixels_1_tdata)
      && $stable(m_axis_pixels_2_tdata) && $stable(m_axis_weights_tdata))
    else $error("Output beat changed or vanished before it was taken.");

  weights_held: assert property (@(posedge aclk) disable iff (reset)
    s_axis_weights_tvalid && !s_axis_weights_tready |=> s_axis_weights_tvalid
      && $stable(s_axis_weights_tlast) && $stable(s_axis_weights_tdata))
    else $error("Weight input beat changed or vanished before it was taken.");

  // Output stays quiet while reset is applied.
  quiet_in_reset: assert property (@(posedge aclk) reset |=> !m_axis_tvalid)
    else $error("m_axis_tvalid high during reset.");

endmodule

bind axis_input_pipe axis_input_pipe_asserts handshake_checks (.*);

`default_nettype wire

// File: axis_input_pipe.sv
`default_nettype none

module axis_input_pipe (
  input  logic                       aclk,
  input  logic                       reset,

  input  logic                       s_axis_pixels_1_tvalid,
  input  logic                       s_axis_pixels_1_tlast,
  input  input_pipe_pkg::pix_edges_t s_axis_pixels_1_tdata,
  output logic                       s_axis_pixels_1_tready,

  input  logic                       s_axis_pixels_2_tvalid,
  input  logic                       s_axis_pixels_2_tlast,
  input  input_pipe_pkg::pix_edges_t s_axis_pixels_2_tdata,
  output logic                       s_axis_pixels_2_tready,

  input  logic                       s_axis_weights_tvalid,
  input  logic                       s_axis_weights_tlast,
  input  input_pipe_pkg::weights_t   s_axis_weights_tdata,
  output logic                       s_axis_weights_tready,

  input  logic                       m_axis_tready,
  output logic                       m_axis_tvalid,
  output logic                       m_axis_tlast,
  output input_pipe_pkg::conv_user_t m_axis_tuser,
  output input_pipe_pkg::pix_units_t m_axis_pixels_1_tdata,
  output input_pipe_pkg::pix_units_t m_axis_pixels_2_tdata,
  output input_pipe_pkg::weights_t   m_axis_weights_tdata
);

  logic                       im_mux_m_ready;
  logic                       im_mux_m_valid;
  input_pipe_pkg::pix_edges_t im_mux_m_data_1;
  input_pipe_pkg::pix_edges_t im_mux_m_data_2;
  input_pipe_pkg::im_user_t   im_mux_m_user;

  logic                       pixels_m_ready;
  logic                       pixels_m_valid;
  input_pipe_pkg::im_user_t   pixels_m_user;

  logic                       weights_m_ready;
  logic                       weights_m_valid;
  logic                       weights_m_last;
  input_pipe_pkg::w_user_t    weights_m_user;

  axis_image_pipe im_mux (
    .aclk            (aclk),
    .reset           (reset),
    .s_axis_1_tvalid (s_axis_pixels_1_tvalid),
    .s_axis_1_tlast  (s_axis_pixels_1_tlast),
    .s_axis_1_tdata  (s_axis_pixels_1_tdata),
    .s_axis_1_tready (s_axis_pixels_1_tready),
    .s_axis_2_tvalid (s_axis_pixels_2_tvalid),
    .s_axis_2_tlast  (s_axis_pixels_2_tlast),
    .s_axis_2_tdata  (s_axis_pixels_2_tdata),
    .s_axis_2_tready (s_axis_pixels_2_tready),
    .m_axis_tready   (im_mux_m_ready),
    .m_axis_tvalid   (im_mux_m_valid),
    .m_axis_1_tdata  (im_mux_m_data_1),
    .m_axis_2_tdata  (im_mux_m_data_2),
    .m_axis_tuser    (im_mux_m_user)
  );

  axis_image_shift_buffer im_shift_1 (
    .aclk          (aclk),
    .reset         (reset),
    .s_axis_tvalid (im_mux_m_valid),
    .s_axis_tdata  (im_mux_m_data_1),
    .s_axis_tuser  (im_mux_m_user),
    .s_axis_tready (im_mux_m_ready),
    .m_axis_tready (pixels_m_ready),
    .m_axis_tvalid (pixels_m_valid),
    .m_axis_tdata  (m_axis_pixels_1_tdata),
    .m_axis_tuser  (pixels_m_user)
  );

  // Same handshakes as im_shift_1, so only its data is taken.
  axis_image_shift_buffer im_shift_2 (
    .aclk          (aclk),
    .reset         (reset),
    .s_axis_tvalid (im_mux_m_valid),
    .s_axis_tdata  (im_mux_m_data_2),
    .s_axis_tuser  (im_mux_m_user),
    .s_axis_tready (),
    .m_axis_tready (pixels_m_ready),
    .m_axis_tvalid (),
    .m_axis_tdata  (m_axis_pixels_2_tdata),
    .m_axis_tuser  ()
  );

  axis_weight_rotator weights_rotator (
    .aclk          (aclk),
    .reset         (reset),
    .s_axis_tvalid (s_axis_weights_tvalid),
    .s_axis_tlast  (s_axis_weights_tlast),
    .s_axis_tdata  (s_axis_weights_tdata),
    .s_axis_tready (s_axis_weights_tready),
    .m_axis_tready (weights_m_ready),
    .m_axis_tvalid (weights_m_valid),
    .m_axis_tlast  (weights_m_last),
    .m_axis_tdata  (m_axis_weights_tdata),
    .m_axis_tuser  (weights_m_user)
  );

  // Pixels and weights leave together.
  assign m_axis_tvalid   = weights_m_valid && pixels_m_valid;
  assign weights_m_ready = m_axis_tready && pixels_m_valid;
  assign pixels_m_ready  = m_axis_tready && weights_m_valid;
  assign m_axis_tlast    = weights_m_last;

  assign m_axis_tuser.is_not_max      = pixels_m_user.is_not_max;
  assign m_axis_tuser.is_max          = pixels_m_user.is_max;
  assign m_axis_tuser.is_lrelu        = pixels_m_user.is_lrelu;
  assign m_axis_tuser.kernel_h_1      = pixels_m_user.kernel_h_1;
  assign m_axis_tuser.is_1x1          = weights_m_user.is_1x1;
  assign m_axis_tuser.kernel_w_1      = weights_m_user.kernel_w_1;
  assign m_axis_tuser.is_top_block    = weights_m_user.is_top_block && m_axis_tvalid;
  assign m_axis_tuser.is_bottom_block = weights_m_user.is_bottom_block && m_axis_tvalid;
  assign m_axis_tuser.is_cols_1_k2    = weights_m_user.is_cols_1_k2 && m_axis_tvalid;
  assign m_axis_tuser.is_cin_last     = weights_m_user.is_cin_last && m_axis_tvalid;

endmodule

`default_nettype wire

// File: axis_weight_rotator.sv
`default_nettype none

module axis_weight_rotator (
  input  logic                     aclk,
  input  logic                     reset,

  input  logic                     s_axis_tvalid,
  input  logic                     s_axis_tlast,
  input  input_pipe_pkg::weights_t s_axis_tdata,
  output logic                     s_axis_tready,

  input  logic                     m_axis_tready,
  output logic                     m_axis_tvalid,
  output logic                     m_axis_tlast,
  output input_pipe_pkg::weights_t m_axis_tdata,
  output input_pipe_pkg::w_user_t  m_axis_tuser
);

  input_pipe_pkg::w_state_e state;
  input_pipe_pkg::weights_t mem [input_pipe_pkg::W_DEPTH];
  input_pipe_pkg::w_cfg_t   cfg_in;
  input_pipe_pkg::word_t    cfg_word;

  input_pipe_pkg::w_addr_t  wr_addr;
  input_pipe_pkg::w_addr_t  rd_addr;
  input_pipe_pkg::w_addr_t  last_addr;   // Address of the final stored beat.
  input_pipe_pkg::blocks_t  block;

  input_pipe_pkg::kw_t      kernel_w_1;
  input_pipe_pkg::blocks_t  blocks_1;
  logic                     is_1x1;
  logic                     is_cols_1_k2;

  logic s_fire;
  logic m_fire;
  logic pass_end;
  logic last_pass;

  assign s_axis_tready = (state != input_pipe_pkg::W_SEND);
  assign s_fire        = s_axis_tvalid && s_axis_tready;

  assign cfg_word = s_axis_tdata[0];
  assign cfg_in   = input_pipe_pkg::w_cfg_t'(cfg_word);

  assign m_axis_tvalid = (state == input_pipe_pkg::W_SEND);
  assign m_fire        = m_axis_tvalid && m_axis_tready;
  assign pass_end      = (rd_addr == last_addr);
  assign last_pass     = (block == blocks_1);

  assign m_axis_tdata  = mem[rd_addr];
  assign m_axis_tlast  = pass_end && last_pass;

  assign m_axis_tuser.is_1x1          = is_1x1;
  assign m_axis_tuser.is_top_block    = (block == '0);
  assign m_axis_tuser.is_bottom_block = last_pass;
  assign m_axis_tuser.is_cols_1_k2    = is_cols_1_k2;
  assign m_axis_tuser.is_cin_last     = pass_end;
  assign m_axis_tuser.kernel_w_1      = kernel_w_1;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state   <= input_pipe_pkg::W_CONFIG;
      wr_addr <= '0;
      rd_addr <= '0;
      block   <= '0;
    end else begin
      case (state)
        input_pipe_pkg::W_CONFIG: begin
          if (s_fire) begin
            state   <= input_pipe_pkg::W_LOAD;
            wr_addr <= '0;
          end
        end
        input_pipe_pkg::W_LOAD: begin
          if (s_fire) begin
            wr_addr <= wr_addr + 1'b1;  // Wraps past W_DEPTH.
            if (s_axis_tlast) begin
              state   <= input_pipe_pkg::W_SEND;
              rd_addr <= '0;
              block   <= '0;
            end
          end
        end
        input_pipe_pkg::W_SEND: begin
          if (m_fire) begin
            if (pass_end) begin
              rd_addr <= '0;
              if (last_pass)
                state <= input_pipe_pkg::W_CONFIG;
              else
                block <= block + 1'b1;
            end else begin
              rd_addr <= rd_addr + 1'b1;
            end
          end
        end
        default: state <= input_pipe_pkg::W_CONFIG;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (s_fire && state == input_pipe_pkg::W_CONFIG) begin
      kernel_w_1   <= cfg_in.kernel_w_1;
      blocks_1     <= cfg_in.blocks_1;
      is_1x1       <= cfg_in.is_1x1;
      is_cols_1_k2 <= cfg_in.is_cols_1_k2;
    end
    if (s_fire && state == input_pipe_pkg::W_LOAD) begin
      mem[wr_addr] <= s_axis_tdata;
      if (s_axis_tlast)
        last_addr <= wr_addr;
    end
  end

endmodule

`default_nettype wire

// File: axis_image_shift_buffer.sv
`default_nettype none

module axis_image_shift_buffer (
  input  logic                      aclk,
  input  logic                      reset,

  input  logic                      s_axis_tvalid,
  input  input_pipe_pkg::pix_edges_t s_axis_tdata,
  input  input_pipe_pkg::im_user_t  s_axis_tuser,
  output logic                      s_axis_tready,

  input  logic                      m_axis_tready,
  output logic                      m_axis_tvalid,
  output input_pipe_pkg::pix_units_t m_axis_tdata,
  output input_pipe_pkg::im_user_t  m_axis_tuser
);

  input_pipe_pkg::pix_edges_t held_data;
  input_pipe_pkg::im_user_t   held_user;
  input_pipe_pkg::kh_t        row;

  logic full;
  logic last_row;
  logic load;
  logic out_fire;

  assign last_row = (row == held_user.kernel_h_1);
  assign out_fire = full && m_axis_tready;

  // Accept the next beat while the last window leaves.
  assign s_axis_tready = !full || (m_axis_tready && last_row);
  assign load          = s_axis_tvalid && s_axis_tready;

  assign m_axis_tvalid = full;
  assign m_axis_tdata  = held_data[row +: input_pipe_pkg::UNITS];   // Words row..row+UNITS-1.
  assign m_axis_tuser  = held_user;

  always_ff @(posedge aclk) begin
    if (reset) begin
      full <= 1'b0;
      row  <= '0;
    end else begin
      if (load)
        full <= 1'b1;
      else if (out_fire && last_row)
        full <= 1'b0;

      if (load)
        row <= '0;
      else if (out_fire)
        row <= last_row ? '0 : row + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      held_data <= s_axis_tdata;
      held_user <= s_axis_tuser;
    end
  end

endmodule

`default_nettype wire

// File: axis_image_pipe.sv
`default_nettype none

module axis_image_pipe (
  input  logic                      aclk,
  input  logic                      reset,

  input  logic                      s_axis_1_tvalid,
  input  logic                      s_axis_1_tlast,
  input  input_pipe_pkg::pix_edges_t s_axis_1_tdata,
  output logic                      s_axis_1_tready,

  input  logic                      s_axis_2_tvalid,
  input  logic                      s_axis_2_tlast,
  input  input_pipe_pkg::pix_edges_t s_axis_2_tdata,
  output logic                      s_axis_2_tready,

  input  logic                      m_axis_tready,
  output logic                      m_axis_tvalid,
  output input_pipe_pkg::pix_edges_t m_axis_1_tdata,
  output input_pipe_pkg::pix_edges_t m_axis_2_tdata,
  output input_pipe_pkg::im_user_t  m_axis_tuser
);

  input_pipe_pkg::im_state_e state;
  input_pipe_pkg::im_user_t  cfg_user;
  input_pipe_pkg::im_cfg_t   cfg;
  input_pipe_pkg::word_t     cfg_word;

  logic free;
  logic accept;
  logic in_last;

  // Config beat costs no output slot, so it is always free.
  assign free    = (state == input_pipe_pkg::IM_CONFIG) || !m_axis_tvalid || m_axis_tready;
  assign accept  = s_axis_1_tvalid && s_axis_2_tvalid && free;
  assign in_last = s_axis_1_tlast || s_axis_2_tlast;

  // Each side waits for the other.
  assign s_axis_1_tready = s_axis_2_tvalid && free;
  assign s_axis_2_tready = s_axis_1_tvalid && free;

  assign cfg_word = s_axis_1_tdata[0];           // Config lives in word 0 of stream 1.
  assign cfg      = input_pipe_pkg::im_cfg_t'(cfg_word);

  always_ff @(posedge aclk) begin
    if (reset) begin
      state         <= input_pipe_pkg::IM_CONFIG;
      m_axis_tvalid <= 1'b0;
    end else begin
      if (accept && state == input_pipe_pkg::IM_PIXELS)
        m_axis_tvalid <= 1'b1;                   // Refill in the cycle it drains.
      else if (m_axis_tready)
        m_axis_tvalid <= 1'b0;

      if (accept) begin
        if (state == input_pipe_pkg::IM_CONFIG)
          state <= input_pipe_pkg::IM_PIXELS;
        else if (in_last)
          state <= input_pipe_pkg::IM_CONFIG;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (accept && state == input_pipe_pkg::IM_CONFIG) begin
      cfg_user.is_not_max <= !cfg.is_max;
      cfg_user.is_max     <= cfg.is_max;
      cfg_user.is_lrelu   <= cfg.is_lrelu;
      cfg_user.kernel_h_1 <= cfg.kernel_h_1;
    end
    if (accept && state == input_pipe_pkg::IM_PIXELS) begin
      m_axis_1_tdata <= s_axis_1_tdata;
      m_axis_2_tdata <= s_axis_2_tdata;
      m_axis_tuser   <= cfg_user;                // Tag with the packet's config.
    end
  end

endmodule

`default_nettype wire

// File: input_pipe_pkg.sv
`default_nettype none

package input_pipe_pkg;

  localparam int UNITS        = 4;
  localparam int CORES        = 2;
  localparam int MEMBERS      = 2;
  localparam int WORD_WIDTH   = 8;
  localparam int KERNEL_H_MAX = 3;                         // Odd.
  localparam int UNITS_EDGES  = UNITS + KERNEL_H_MAX - 1;  // Pixel words incl. edges.
  localparam int W_DEPTH      = 16;
  localparam int BLOCKS_MAX   = 8;

  localparam int W_WORDS     = CORES * MEMBERS;
  localparam int BITS_KERNEL = $clog2(KERNEL_H_MAX);

  typedef logic [WORD_WIDTH-1:0]           word_t;
  typedef logic [BITS_KERNEL-1:0]          kh_t;       // Kernel height minus one.
  typedef logic [BITS_KERNEL-1:0]          kw_t;       // Kernel width minus one.
  typedef logic [$clog2(BLOCKS_MAX)-1:0]   blocks_t;
  typedef logic [$clog2(W_DEPTH)-1:0]      w_addr_t;
  typedef word_t [UNITS_EDGES-1:0]         pix_edges_t;
  typedef word_t [UNITS-1:0]               pix_units_t;
  typedef word_t [W_WORDS-1:0]             weights_t;

  typedef struct packed {
    logic is_not_max;
    logic is_max;
    logic is_lrelu;
    kh_t  kernel_h_1;
  } im_user_t;

  typedef struct packed {
    logic is_1x1;
    logic is_top_block;
    logic is_bottom_block;
    logic is_cols_1_k2;
    logic is_cin_last;
    kw_t  kernel_w_1;
  } w_user_t;

  // Sideband seen by the conv engine.
  typedef struct packed {
    logic is_not_max;
    logic is_max;
    logic is_1x1;
    logic is_lrelu;
    logic is_top_block;
    logic is_bottom_block;
    logic is_cols_1_k2;
    logic is_cin_last;
    kw_t  kernel_w_1;
    kh_t  kernel_h_1;
  } conv_user_t;

  typedef struct packed {
    logic [3:0] reserved;
    logic       is_lrelu;
    logic       is_max;
    kh_t        kernel_h_1;
  } im_cfg_t;

  typedef struct packed {
    logic    reserved;
    logic    is_cols_1_k2;
    logic    is_1x1;
    blocks_t blocks_1;
    kw_t     kernel_w_1;
  } w_cfg_t;

  typedef enum logic {IM_CONFIG, IM_PIXELS} im_state_e;
  typedef enum logic [1:0] {W_CONFIG, W_LOAD, W_SEND} w_state_e;

endpackage

`default_nettype wire
